// File: verilog/cd_audio_pkg.sv
////////////////////////////////////////////////////////////
// cd audio stream, shared widths, types and constants
////////////////////////////////////////////////////////////

`default_nettype none

package cd_audio_pkg;

	////////////////////////////////////////////////////////////
	// data types

	typedef logic signed [15:0] sample_t;	// signed pcm sample
	typedef logic [15:0] word_t;		// raw memory word, stored byte order
	typedef logic [22:0] mem_addr_t;	// word address into sdram

	////////////////////////////////////////////////////////////
	// ring buffer placement

	// 0x6f0000 bytes -> word address
	localparam mem_addr_t AUD_BASE_ADDR = 23'h378000;

	// 32k words, two 16k halves for the host
	localparam int RING_ADDR_BITS_DEFAULT = 15;

	////////////////////////////////////////////////////////////
	// fifo and pacing

	localparam int FIFO_DEPTH = 16;		// words, power of two
	localparam int FIFO_LEVEL_BITS = 5;	// holds 0..FIFO_DEPTH

	// 114.75 MHz / 44.1 kHz, one stereo frame
	localparam int SAMPLE_PERIOD = 2602;

	////////////////////////////////////////////////////////////
	// player FSM

	typedef enum logic [1:0] {
		PS_IDLE,	// waiting for the next tick
		PS_WAIT_L,	// popping left word
		PS_WAIT_R	// popping right word
	} player_state_t;

endpackage

`default_nettype wire

// File: verilog/stream_fetch.sv
////////////////////////////////////////////////////////////
// stream fetcher, reads the audio ring from memory within
// fifo credit and pushes the returned words
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module stream_fetch #(
	parameter int ring_addr_bits = cd_audio_pkg::RING_ADDR_BITS_DEFAULT
) (
	input wire CLK_114,
	input wire rst,
	input wire enable,
	// memory read
	output logic mem_req,
	output cd_audio_pkg::mem_addr_t mem_addr,
	input wire mem_ready,
	input wire mem_rvalid,
	input wire cd_audio_pkg::word_t mem_rdata,
	// host side
	output logic buf_half,		// half the fetcher is working in
	// fifo push
	input wire [cd_audio_pkg::FIFO_LEVEL_BITS-1:0] fifo_free,
	output logic push_valid,
	output cd_audio_pkg::word_t push_data,
	input wire push_ready
);

	logic [ring_addr_bits-1:0] ring_off;		// word offset into the ring
	logic [cd_audio_pkg::FIFO_LEVEL_BITS-1:0] in_flight;	// accepted, not yet returned
	logic active;		// stream running, no stale reads pending
	logic accept;

	// credit: words in flight must fit in the fifo's free space
	assign mem_req = active && enable && (in_flight < fifo_free);
	assign accept = mem_req && mem_ready;
	assign mem_addr = cd_audio_pkg::AUD_BASE_ADDR + cd_audio_pkg::mem_addr_t'(ring_off);

	// returns from before a disable are dropped on the floor
	assign push_valid = mem_rvalid && active && enable;
	assign push_data = mem_rdata;

	////////////////////////////////////////////////////////////
	// ring pointer and outstanding count

	always_ff @(posedge CLK_114) begin
		if (rst) begin
			ring_off <= '0;
			in_flight <= '0;
			active <= 1'b0;
			buf_half <= 1'b0;
		end else begin
			// count tracks stale reads too, so it survives a disable
			case ({accept, mem_rvalid})
				2'b10: in_flight <= in_flight + 1'b1;
				2'b01: in_flight <= in_flight - 1'b1;
				default: in_flight <= in_flight;
			endcase

			if (!enable) begin
				active <= 1'b0;		// flush, restart at base
				ring_off <= '0;
				buf_half <= 1'b0;
			end else begin
				if (!active && in_flight == '0)
					active <= 1'b1;	// old reads drained
				if (accept) begin
					ring_off <= ring_off + 1'b1;	// wraps at ring size
					buf_half <= ring_off[ring_addr_bits-1];
				end
			end
		end
	end

	////////////////////////////////////////////////////////////
	// checks

	// a waiting request keeps its address until taken or disabled
	a_addr_hold: assert property (@(posedge CLK_114) disable iff (rst)
		(mem_req && !mem_ready) |=> (!enable || (mem_req && $stable(mem_addr))))
		else $error("mem_addr changed while request waiting");

	// credit scheme must keep room for every return
	a_push_taken: assert property (@(posedge CLK_114) disable iff (rst)
		push_valid |-> push_ready)
		else $error("fifo refused a returned word");

endmodule

`default_nettype wire

// File: verilog/sample_fifo.sv
////////////////////////////////////////////////////////////
// sample word fifo with free count and flush on disable
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module sample_fifo (
	input wire CLK_114,
	input wire rst,
	input wire enable,		// low flushes
	// push side
	input wire push_valid,
	input wire cd_audio_pkg::word_t push_data,
	output logic push_ready,
	// pop side
	output logic pop_valid,
	output cd_audio_pkg::word_t pop_data,
	input wire pop_ready,
	// credit for the fetcher
	output logic [cd_audio_pkg::FIFO_LEVEL_BITS-1:0] fifo_free
);

	cd_audio_pkg::word_t mem [cd_audio_pkg::FIFO_DEPTH];
	logic [cd_audio_pkg::FIFO_LEVEL_BITS-2:0] wr_ptr;
	logic [cd_audio_pkg::FIFO_LEVEL_BITS-2:0] rd_ptr;
	logic [cd_audio_pkg::FIFO_LEVEL_BITS-1:0] level;	// words held
	logic full;
	logic do_push;
	logic do_pop;

	assign full = (level == cd_audio_pkg::FIFO_LEVEL_BITS'(cd_audio_pkg::FIFO_DEPTH));
	assign push_ready = enable && !full;
	assign pop_valid = enable && (level != '0);
	assign pop_data = mem[rd_ptr];		// head word, async read
	assign fifo_free = cd_audio_pkg::FIFO_LEVEL_BITS'(cd_audio_pkg::FIFO_DEPTH) - level;

	assign do_push = push_valid && push_ready;
	assign do_pop = pop_valid && pop_ready;

	// storage
	always_ff @(posedge CLK_114) begin
		if (do_push)
			mem[wr_ptr] <= push_data;
	end

	////////////////////////////////////////////////////////////
	// pointers and level

	always_ff @(posedge CLK_114) begin
		if (rst || !enable) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			level <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;	// pointers wrap on depth
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10: level <= level + 1'b1;
				2'b01: level <= level - 1'b1;
				default: level <= level;	// both or neither
			endcase
		end
	end

	// fetcher credit should never offer a word to a full fifo
	a_no_overflow: assert property (@(posedge CLK_114) disable iff (rst)
		(push_valid && enable) |-> !full)
		else $error("push offered while fifo full");

	// level tracks the pointers and never wraps below zero
	a_no_underflow: assert property (@(posedge CLK_114) disable iff (rst)
		(level <= cd_audio_pkg::FIFO_LEVEL_BITS'(cd_audio_pkg::FIFO_DEPTH)) &&
		(level[cd_audio_pkg::FIFO_LEVEL_BITS-2:0] == wr_ptr - rd_ptr))
		else $error("fifo level out of step with pointers");

endmodule

`default_nettype wire

// File: verilog/frame_player.sv
////////////////////////////////////////////////////////////
// frame player, paces stereo frames at the sample rate and
// pops byte-swapped left and right samples
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module frame_player (
	input wire CLK_114,
	input wire rst,
	input wire enable,
	// fifo pop
	input wire pop_valid,
	input wire cd_audio_pkg::word_t pop_data,
	output logic pop_ready,
	// stream samples
	output cd_audio_pkg::sample_t stream_l,
	output cd_audio_pkg::sample_t stream_r,
	output logic frame_stb,		// one cycle after a frame completes
	output logic underrun		// tick came while still collecting
);

	logic [$clog2(cd_audio_pkg::SAMPLE_PERIOD)-1:0] div_cnt;
	logic tick;
	cd_audio_pkg::player_state_t state;
	cd_audio_pkg::sample_t left_q;		// left half of the frame

	// samples are stored little-endian
	function automatic cd_audio_pkg::sample_t swap_bytes(input cd_audio_pkg::word_t w);
		return cd_audio_pkg::sample_t'({w[7:0], w[15:8]});
	endfunction

	assign pop_ready = (state == cd_audio_pkg::PS_WAIT_L) ||
		(state == cd_audio_pkg::PS_WAIT_R);

	////////////////////////////////////////////////////////////
	// sample rate divider

	always_ff @(posedge CLK_114) begin
		if (rst || !enable) begin
			div_cnt <= '0;
			tick <= 1'b0;
		end else if (div_cnt == $bits(div_cnt)'(cd_audio_pkg::SAMPLE_PERIOD - 1)) begin
			div_cnt <= '0;
			tick <= 1'b1;		// one pulse per frame period
		end else begin
			div_cnt <= div_cnt + 1'b1;
			tick <= 1'b0;
		end
	end

	////////////////////////////////////////////////////////////
	// frame FSM

	always_ff @(posedge CLK_114) begin
		if (rst || !enable) begin
			state <= cd_audio_pkg::PS_IDLE;
			stream_l <= '0;		// silent while stopped
			stream_r <= '0;
			frame_stb <= 1'b0;
			underrun <= 1'b0;
		end else begin
			frame_stb <= 1'b0;
			// late data, this tick is lost
			underrun <= tick && (state != cd_audio_pkg::PS_IDLE);
			case (state)
				cd_audio_pkg::PS_IDLE:
					if (tick)
						state <= cd_audio_pkg::PS_WAIT_L;
				cd_audio_pkg::PS_WAIT_L:
					if (pop_valid)
						state <= cd_audio_pkg::PS_WAIT_R;
				cd_audio_pkg::PS_WAIT_R:
					if (pop_valid) begin
						stream_l <= left_q;	// both channels change together
						stream_r <= swap_bytes(pop_data);
						frame_stb <= 1'b1;
						state <= cd_audio_pkg::PS_IDLE;
					end
				default: state <= cd_audio_pkg::PS_IDLE;
			endcase
		end
	end

	// left word parked until the right one arrives
	always_ff @(posedge CLK_114) begin
		if (state == cd_audio_pkg::PS_WAIT_L && pop_valid)
			left_q <= swap_bytes(pop_data);
	end

	// a frame needs the tick and both pops in enabled cycles
	a_no_stb_after_disable: assert property (@(posedge CLK_114) disable iff (rst)
		frame_stb |-> ($past(enable) && $past(enable, 2) && $past(enable, 3) &&
			$past(enable, 4)))
		else $error("frame_stb without a fully enabled frame");

endmodule

`default_nettype wire

// File: verilog/audio_mixer.sv
////////////////////////////////////////////////////////////
// audio mixer, saturating sum of stream and amiga audio
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module audio_mixer (
	input wire CLK_114,
	input wire rst,
	input wire cd_audio_pkg::sample_t stream_l,
	input wire cd_audio_pkg::sample_t stream_r,
	input wire cd_audio_pkg::sample_t amiga_l,
	input wire cd_audio_pkg::sample_t amiga_r,
	input wire frame_stb,
	output cd_audio_pkg::sample_t audio_l,
	output cd_audio_pkg::sample_t audio_r,
	output logic sample_stb		// new frame visible on audio_l/r
);

	// 17 bit sum, clamp to 16 bit range
	function automatic cd_audio_pkg::sample_t sat_add(input cd_audio_pkg::sample_t a,
		input cd_audio_pkg::sample_t b);
		logic signed [16:0] sum;
		sum = {a[15], a} + {b[15], b};
		if (sum[16:15] == 2'b01)
			return 16'h7fff;	// positive overflow
		else if (sum[16:15] == 2'b10)
			return 16'h8000;	// negative overflow
		else
			return sum[15:0];
	endfunction

	always_ff @(posedge CLK_114) begin
		if (rst) begin
			audio_l <= '0;
			audio_r <= '0;
			sample_stb <= 1'b0;
		end else begin
			audio_l <= sat_add(stream_l, amiga_l);
			audio_r <= sat_add(stream_r, amiga_r);
			sample_stb <= frame_stb;	// lines up with the new sum
		end
	end

	a_reset_quiet: assert property (@(posedge CLK_114)
		rst |=> (audio_l == '0 && audio_r == '0 && !sample_stb))
		else $error("mixer outputs not cleared by reset");

endmodule

`default_nettype wire

// File: verilog/cd_audio_top.sv
////////////////////////////////////////////////////////////
// cd audio streaming top, fetcher, fifo, player and mixer
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module cd_audio_top #(
	parameter int ring_addr_bits = cd_audio_pkg::RING_ADDR_BITS_DEFAULT
) (
	input wire CLK_114,
	input wire rst,
	input wire enable,
	// memory read port
	output logic mem_req,
	output cd_audio_pkg::mem_addr_t mem_addr,
	input wire mem_ready,
	input wire mem_rvalid,
	input wire cd_audio_pkg::word_t mem_rdata,
	output logic buf_half,
	// native amiga audio in, mixed audio out
	input wire cd_audio_pkg::sample_t amiga_l,
	input wire cd_audio_pkg::sample_t amiga_r,
	output cd_audio_pkg::sample_t audio_l,
	output cd_audio_pkg::sample_t audio_r,
	output logic sample_stb,
	output logic underrun
);

	////////////////////////////////////////////////////////////
	// internal nets

	logic [cd_audio_pkg::FIFO_LEVEL_BITS-1:0] fifo_free;
	logic push_valid;
	logic push_ready;
	cd_audio_pkg::word_t push_data;
	logic pop_valid;
	logic pop_ready;
	cd_audio_pkg::word_t pop_data;
	cd_audio_pkg::sample_t stream_l;
	cd_audio_pkg::sample_t stream_r;
	logic frame_stb;

	// producer
	stream_fetch #(.ring_addr_bits(ring_addr_bits)) i_stream_fetch (
		.CLK_114(CLK_114),
		.rst(rst),
		.enable(enable),
		.mem_req(mem_req),
		.mem_addr(mem_addr),
		.mem_ready(mem_ready),
		.mem_rvalid(mem_rvalid),
		.mem_rdata(mem_rdata),
		.buf_half(buf_half),
		.fifo_free(fifo_free),
		.push_valid(push_valid),
		.push_data(push_data),
		.push_ready(push_ready)
	);

	sample_fifo i_sample_fifo (
		.CLK_114(CLK_114),
		.rst(rst),
		.enable(enable),
		.push_valid(push_valid),
		.push_data(push_data),
		.push_ready(push_ready),
		.pop_valid(pop_valid),
		.pop_data(pop_data),
		.pop_ready(pop_ready),
		.fifo_free(fifo_free)
	);

	// consumer
	frame_player i_frame_player (
		.CLK_114(CLK_114),
		.rst(rst),
		.enable(enable),
		.pop_valid(pop_valid),
		.pop_data(pop_data),
		.pop_ready(pop_ready),
		.stream_l(stream_l),
		.stream_r(stream_r),
		.frame_stb(frame_stb),
		.underrun(underrun)
	);

	audio_mixer i_audio_mixer (
		.CLK_114(CLK_114),
		.rst(rst),
		.stream_l(stream_l),
		.stream_r(stream_r),
		.amiga_l(amiga_l),
		.amiga_r(amiga_r),
		.frame_stb(frame_stb),
		.audio_l(audio_l),
		.audio_r(audio_r),
		.sample_stb(sample_stb)
	);

endmodule

`default_nettype wire

// File: tests/mem_model.sv
////////////////////////////////////////////////////////////
// memory responder, random ready and in-order returns
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module mem_model (
	input wire CLK_114,
	input wire rst,
	input wire stall,		// forces ready low
	input wire mem_req,
	input wire cd_audio_pkg::mem_addr_t mem_addr,
	output logic mem_ready,
	output logic mem_rvalid,
	output cd_audio_pkg::word_t mem_rdata
);

	cd_audio_pkg::mem_addr_t addr_q[$];	// accepted, not returned
	int due_q[$];		// return cycle per entry
	int cycle = 0;
	int last_due = 0;
	int stall_left = 0;

	// stored word, fixed hash of the ring offset
	function automatic cd_audio_pkg::word_t word_at(input cd_audio_pkg::mem_addr_t addr);
		logic [15:0] off;
		off = 16'(addr - cd_audio_pkg::AUD_BASE_ADDR);
		return 16'(off * 16'h4d3b) ^ 16'ha55a;
	endfunction

	// idle bus before the first edge
	initial begin
		mem_ready <= 1'b0;
		mem_rvalid <= 1'b0;
		mem_rdata <= '0;
	end

	always @(posedge CLK_114) begin
		int due;
		cycle = cycle + 1;
		if (rst) begin
			addr_q.delete();
			due_q.delete();
			mem_ready <= 1'b0;
			mem_rvalid <= 1'b0;
			mem_rdata <= '0;
		end else begin
			if (mem_req && mem_ready) begin
				due = cycle + 1 + int'($urandom_range(3));	// 1 to 4 cycles
				if (due <= last_due)
					due = last_due + 1;	// keep request order
				last_due = due;
				addr_q.push_back(mem_addr);
				due_q.push_back(due);
			end
			// one return per cycle at most
			if (due_q.size() > 0 && due_q[0] <= cycle) begin
				mem_rvalid <= 1'b1;
				mem_rdata <= word_at(addr_q.pop_front());
				void'(due_q.pop_front());
			end else begin
				mem_rvalid <= 1'b0;
			end
			if (stall) begin
				mem_ready <= 1'b0;
			end else if (stall_left > 0) begin
				stall_left = stall_left - 1;
				mem_ready <= 1'b0;
			end else if ($urandom_range(63) == 0) begin
				stall_left = 1 + int'($urandom_range(15));	// short busy stretch
				mem_ready <= 1'b0;
			end else begin
				mem_ready <= ($urandom_range(3) != 0);
			end
		end
	end

endmodule

`default_nettype wire

// File: tests/tb_cd_audio.sv
////////////////////////////////////////////////////////////
// testbench for the cd audio stream top level
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_cd_audio;

	localparam int RING_BITS = 6;
	localparam int RING_WORDS = 1 << RING_BITS;	// 64 word ring
	localparam int SEED = 45376;
	localparam int FRAMES_STREAM = 40;
	localparam int FRAMES_SAT = 16;
	localparam int STALL_FRAMES = 12;	// longer than the fifo can cover
	localparam int FRAMES_RESUME = 8;
	localparam int FRAMES_RESTART = 10;
	localparam int TOTAL_FRAMES = FRAMES_STREAM + FRAMES_SAT + STALL_FRAMES +
		FRAMES_RESUME + FRAMES_RESTART;
	localparam int CYCLE_LIMIT = 2 * TOTAL_FRAMES * cd_audio_pkg::SAMPLE_PERIOD + 2000;

	logic CLK_114;
	logic rst;
	logic enable;
	logic stall;
	logic mem_req;
	logic mem_ready;
	logic mem_rvalid;
	logic buf_half;
	logic sample_stb;
	logic underrun;
	cd_audio_pkg::mem_addr_t mem_addr;
	cd_audio_pkg::word_t mem_rdata;
	cd_audio_pkg::sample_t amiga_l;
	cd_audio_pkg::sample_t amiga_r;
	cd_audio_pkg::sample_t audio_l;
	cd_audio_pkg::sample_t audio_r;

	int frame_idx = 0;	// next expected frame
	int sat_hits = 0;
	int exp_off = 0;	// next expected ring offset
	int wraps = 0;
	logic half_pending = 1'b0;
	logic half_exp = 1'b0;
	int underrun_count = 0;
	int cycles = 0;

	cd_audio_top #(.ring_addr_bits(RING_BITS)) i_cd_audio_top (
		.CLK_114(CLK_114),
		.rst(rst),
		.enable(enable),
		.mem_req(mem_req),
		.mem_addr(mem_addr),
		.mem_ready(mem_ready),
		.mem_rvalid(mem_rvalid),
		.mem_rdata(mem_rdata),
		.buf_half(buf_half),
		.amiga_l(amiga_l),
		.amiga_r(amiga_r),
		.audio_l(audio_l),
		.audio_r(audio_r),
		.sample_stb(sample_stb),
		.underrun(underrun)
	);

	mem_model i_mem_model (
		.CLK_114(CLK_114),
		.rst(rst),
		.stall(stall),
		.mem_req(mem_req),
		.mem_addr(mem_addr),
		.mem_ready(mem_ready),
		.mem_rvalid(mem_rvalid),
		.mem_rdata(mem_rdata)
	);

	always #4 CLK_114 = ~CLK_114;	// 8 ns period

	////////////////////////////////////////////////////////////
	// reference model and checks

	// word the memory holds at a ring offset
	function automatic logic [15:0] ring_word(input int off);
		logic [15:0] o;
		o = 16'(off);
		return 16'(o * 16'h4d3b) ^ 16'ha55a;
	endfunction

	// mixed output of one channel of frame k
	function automatic int expected_sample(input int frame, input int chan, input int amiga);
		logic [15:0] w;
		int stream;
		int sum;
		w = ring_word((2 * frame + chan) % RING_WORDS);
		stream = int'($signed({w[7:0], w[15:8]}));	// little-endian word
		sum = stream + amiga;
		if (sum > 32767)
			return 32767;
		if (sum < -32768)
			return -32768;
		return sum;
	endfunction

	task automatic abort_run();
		$display("*** TEST FAILED ***");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic check_value(input string name, input logic signed [31:0] got,
		input logic signed [31:0] exp);
		if (got !== exp) begin
			$display("FAILED t=%0t %s got %0d expected %0d", $time, name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_reset_outputs();
		check_value("mem_req", mem_req, 0);
		check_value("sample_stb", sample_stb, 0);
		check_value("underrun", underrun, 0);
		check_value("buf_half", buf_half, 0);
		check_value("audio_l", audio_l, 0);
		check_value("audio_r", audio_r, 0);
	endtask

	// returns on the edge that saw the n-th strobe
	task automatic wait_frames(input int n);
		repeat (n) begin
			@(posedge CLK_114);
			while (!sample_stb)
				@(posedge CLK_114);
		end
	endtask

	// frame compare
	always @(posedge CLK_114) begin
		int exp_l;
		int exp_r;
		if (!enable) begin
			frame_idx <= 0;		// sequence restarts with the ring
		end else if (sample_stb) begin
			exp_l = expected_sample(frame_idx, 0, amiga_l);
			exp_r = expected_sample(frame_idx, 1, amiga_r);
			check_value("audio_l", audio_l, exp_l);
			check_value("audio_r", audio_r, exp_r);
			if (exp_l == 32767 || exp_l == -32768 || exp_r == 32767 || exp_r == -32768)
				sat_hits <= sat_hits + 1;
			frame_idx <= frame_idx + 1;
		end
	end

	// request addresses and buffer half
	always @(posedge CLK_114) begin
		if (half_pending)
			check_value("buf_half", buf_half, half_exp);
		half_pending <= 1'b0;
		if (rst || !enable) begin
			exp_off <= 0;
		end else if (mem_req && mem_ready) begin
			check_value("mem_addr", mem_addr, int'(cd_audio_pkg::AUD_BASE_ADDR) + exp_off);
			half_pending <= 1'b1;
			half_exp <= exp_off[RING_BITS-1];
			if (exp_off == RING_WORDS - 1) begin
				exp_off <= 0;
				wraps <= wraps + 1;
			end else begin
				exp_off <= exp_off + 1;
			end
		end
	end

	always @(posedge CLK_114) begin
		if (underrun)
			underrun_count <= underrun_count + 1;
	end

	// run limit
	always @(posedge CLK_114) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("ERROR: timeout after %0d cycles, frames stopped arriving", cycles);
			abort_run();
		end
	end

	////////////////////////////////////////////////////////////
	// stimulus

	initial begin
		int under_before;
		int sat_before;
		void'($urandom(SEED));
		CLK_114 = 1'b0;
		rst = 1'b1;
		enable = 1'b0;
		stall = 1'b0;
		amiga_l = '0;
		amiga_r = '0;

		// reset state, 4 cycles high
		@(posedge CLK_114);
		repeat (3) begin
			@(posedge CLK_114);
			check_reset_outputs();
		end
		rst <= 1'b0;
		repeat (2) begin
			@(posedge CLK_114);
			check_reset_outputs();
		end

		// stream order, byte swap, ring wrap
		enable <= 1'b1;
		wait_frames(1);
		amiga_l <= 16'sh0123;
		amiga_r <= -16'sh0456;
		wait_frames(FRAMES_STREAM - 1);
		if (wraps == 0) begin
			$display("ERROR: ring address never wrapped back to the base");
			abort_run();
		end

		// amiga near the limits
		sat_before = sat_hits;
		amiga_l <= 16'sh7f00;
		amiga_r <= -16'sh7f00;
		wait_frames(FRAMES_SAT);
		if (sat_hits == sat_before) begin
			$display("ERROR: no frame reached the saturation limits");
			abort_run();
		end

		// long memory stall drains the fifo
		under_before = underrun_count;
		stall <= 1'b1;
		repeat (STALL_FRAMES * cd_audio_pkg::SAMPLE_PERIOD) @(posedge CLK_114);
		stall <= 1'b0;
		if (underrun_count == under_before) begin
			$display("ERROR: memory stall did not cause an underrun");
			abort_run();
		end
		wait_frames(FRAMES_RESUME);

		// disable, stream goes silent
		wait_frames(1);
		enable <= 1'b0;
		amiga_l <= 16'sh0222;
		amiga_r <= -16'sh0333;
		repeat (3) @(posedge CLK_114);
		check_value("sample_stb", sample_stb, 0);
		check_value("audio_l", audio_l, 16'sh0222);
		check_value("audio_r", audio_r, -16'sh0333);
		repeat (20) @(posedge CLK_114);

		// restart from the ring base
		enable <= 1'b1;
		@(posedge CLK_114);
		while (!(mem_req && mem_ready))
			@(posedge CLK_114);
		check_value("mem_addr", mem_addr, int'(cd_audio_pkg::AUD_BASE_ADDR));
		wait_frames(FRAMES_RESTART);

		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire

// File: all.f
verilog/cd_audio_pkg.sv
verilog/stream_fetch.sv
verilog/sample_fifo.sv
verilog/frame_player.sv
verilog/audio_mixer.sv
verilog/cd_audio_top.sv
tests/mem_model.sv
tests/tb_cd_audio.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the cd audio testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
FAIL_MSG='*** TEST FAILED ***'
PASS_MSG='*** TEST PASSED ***'

verilator --binary --timing --assert -Wno-fatal --top-module tb_cd_audio \
	-f all.f --Mdir obj_dir -o sim_cd_audio
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/sim_cd_audio > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -qF "$FAIL_MSG" "$LOG"; then
	echo "simulation reported a failure, see $LOG"
	exit 1
fi
if [ $sim_status -ne 0 ]; then
	echo "simulator exited with status $sim_status"
	exit 1
fi
if ! grep -qF "$PASS_MSG" "$LOG"; then
	echo "simulation ended without a result, see $LOG"
	exit 1
fi
exit 0
